//--- design/bias_writer.sv
module bias_writer (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_load_base,
  input  sa_ctrl_pkg::mem_addr_t i_y_base,
  input  logic                   i_valid,
  input  sa_cfg_pkg::y_vec_t     i_col,
  input  sa_cfg_pkg::a_vec_t     i_bias,
  output logic                   o_wen,
  output sa_ctrl_pkg::mem_addr_t o_addr,
  output sa_cfg_pkg::y_vec_t     o_data
);

  // Per-row sum, wraps at WY bits
  always_ff @(posedge clk) begin
    if (i_valid) begin
      for (int r = 0; r < sa_cfg_pkg::R; r++) begin
        o_data[r] <= $signed(i_col[r]) + $signed(i_bias[r]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wen <= 1'b0;
    end else begin
      o_wen <= i_valid;
    end
  end

  // Y beats land at consecutive words
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_addr <= '0;
    end else if (i_load_base) begin
      o_addr <= i_y_base;
    end else if (o_wen) begin
      o_addr <= o_addr + 1'b1;
    end
  end

endmodule

//--- design/mem_reader.sv
module mem_reader (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_load_base,
  input  sa_ctrl_pkg::mem_addr_t i_base,
  input  logic                   i_next,
  output logic                   o_ren,
  output sa_ctrl_pkg::mem_addr_t o_addr,
  output logic                   o_valid
);

  assign o_ren = i_next;

  // Word address steps once per issued read
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_addr <= '0;
    end else if (i_load_base) begin
      o_addr <= i_base;
    end else if (i_next) begin
      o_addr <= o_addr + 1'b1;
    end
  end

  // RAM returns data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_next;
    end
  end

endmodule

//--- design/pe_array.sv
module pe_array (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_clr,
  input  logic               i_acc_en,
  input  sa_cfg_pkg::k_vec_t i_k,
  input  sa_cfg_pkg::x_vec_t i_x,
  input  logic               i_drain,
  output sa_cfg_pkg::y_vec_t o_col
);

  logic signed [sa_cfg_pkg::WY-1:0] acc [sa_cfg_pkg::R][sa_cfg_pkg::C];
  logic [$clog2(sa_cfg_pkg::C)-1:0] col_ptr;

  // One MAC per cell, outer product of the X and K beats
  for (genvar r = 0; r < sa_cfg_pkg::R; r++) begin : g_row
    for (genvar c = 0; c < sa_cfg_pkg::C; c++) begin : g_col
      always_ff @(posedge clk) begin
        if (i_clr) begin
          acc[r][c] <= '0;
        end else if (i_acc_en) begin
          acc[r][c] <= acc[r][c] + $signed(i_x[r]) * $signed(i_k[c]);
        end
      end
    end
  end

  // Drain pointer walks columns left to right
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clr) begin
      col_ptr <= '0;
    end else if (i_drain) begin
      col_ptr <= col_ptr + 1'b1;
    end
  end

  always_comb begin
    for (int r = 0; r < sa_cfg_pkg::R; r++) begin
      o_col[r] = acc[r][col_ptr];
    end
  end

endmodule

//--- design/sa_cfg_pkg.sv
package sa_cfg_pkg;

  // Array geometry
  localparam int R = 4;
  localparam int C = 4;

  // Element widths
  localparam int WX = 8;
  localparam int WK = 8;
  localparam int WY = 32;
  localparam int WA = 32;

  // One RAM beat per vector, elements read as signed
  typedef logic [R-1:0][WX-1:0] x_vec_t;
  typedef logic [C-1:0][WK-1:0] k_vec_t;

  // Drained column and its bias, one element per row
  typedef logic [R-1:0][WY-1:0] y_vec_t;
  typedef logic [R-1:0][WA-1:0] a_vec_t;

endpackage

//--- design/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

  localparam int MEM_AW = 16;
  typedef logic [MEM_AW-1:0] mem_addr_t;

  localparam int REG_AW = 32;
  localparam int REG_DW = 32;
  localparam logic [REG_AW-1:0] REG_BASE_ADDR = 32'hB000_0000;

  localparam int LEN_W = 16;

  // Cycles spent in FINISH while the last bias write drains
  localparam int FINISH_CYC = 3;

  // Word index of each register
  typedef enum logic [REG_AW-3:0] {
    REG_CTRL   = 0,
    REG_STATUS = 1,
    REG_K_BASE = 2,
    REG_X_BASE = 3,
    REG_A_BASE = 4,
    REG_Y_BASE = 5,
    REG_LEN    = 6
  } reg_idx_e;

  typedef enum logic [1:0] {IDLE, LOAD, DRAIN, FINISH} seq_state_e;

endpackage

//--- design/sa_ctrl_regs.sv
module sa_ctrl_regs (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  logic                             i_reg_wr_en,
  input  logic [sa_ctrl_pkg::REG_AW-1:0]   i_reg_wr_addr,
  input  logic [sa_ctrl_pkg::REG_DW-1:0]   i_reg_wr_data,
  input  logic [sa_ctrl_pkg::REG_DW/8-1:0] i_reg_wr_strb,
  input  logic                             i_reg_rd_en,
  input  logic [sa_ctrl_pkg::REG_AW-1:0]   i_reg_rd_addr,
  input  logic                             i_run_end,
  output logic [sa_ctrl_pkg::REG_DW-1:0]   o_reg_rd_data,
  output logic                             o_start,
  output logic [sa_ctrl_pkg::LEN_W-1:0]    o_len,
  output sa_ctrl_pkg::mem_addr_t           o_k_base,
  output sa_ctrl_pkg::mem_addr_t           o_x_base,
  output sa_ctrl_pkg::mem_addr_t           o_a_base,
  output sa_ctrl_pkg::mem_addr_t           o_y_base
);

  logic [sa_ctrl_pkg::REG_AW-1:0] wr_off;
  logic [sa_ctrl_pkg::REG_AW-1:0] rd_off;
  sa_ctrl_pkg::reg_idx_e          wr_idx;
  sa_ctrl_pkg::reg_idx_e          rd_idx;
  logic [sa_ctrl_pkg::REG_DW-1:0] k_base_q;
  logic [sa_ctrl_pkg::REG_DW-1:0] x_base_q;
  logic [sa_ctrl_pkg::REG_DW-1:0] a_base_q;
  logic [sa_ctrl_pkg::REG_DW-1:0] y_base_q;
  logic [sa_ctrl_pkg::REG_DW-1:0] len_q;
  logic [sa_ctrl_pkg::REG_DW-1:0] rd_mux;
  logic                           start_req;
  logic                           busy;
  logic                           done;

  function automatic logic [sa_ctrl_pkg::REG_DW-1:0] merge_bytes(
    input logic [sa_ctrl_pkg::REG_DW-1:0]   old_val,
    input logic [sa_ctrl_pkg::REG_DW-1:0]   new_val,
    input logic [sa_ctrl_pkg::REG_DW/8-1:0] strb
  );
    logic [sa_ctrl_pkg::REG_DW-1:0] res;
    res = old_val;
    for (int b = 0; b < sa_ctrl_pkg::REG_DW / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Byte offset from the block base, then word index
  assign wr_off = i_reg_wr_addr - sa_ctrl_pkg::REG_BASE_ADDR;
  assign rd_off = i_reg_rd_addr - sa_ctrl_pkg::REG_BASE_ADDR;
  assign wr_idx = sa_ctrl_pkg::reg_idx_e'(wr_off[sa_ctrl_pkg::REG_AW-1:2]);
  assign rd_idx = sa_ctrl_pkg::reg_idx_e'(rd_off[sa_ctrl_pkg::REG_AW-1:2]);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      k_base_q <= '0;
      x_base_q <= '0;
      a_base_q <= '0;
      y_base_q <= '0;
      len_q    <= '0;
    end else if (i_reg_wr_en) begin
      case (wr_idx)
        sa_ctrl_pkg::REG_K_BASE: k_base_q <= merge_bytes(k_base_q, i_reg_wr_data, i_reg_wr_strb);
        sa_ctrl_pkg::REG_X_BASE: x_base_q <= merge_bytes(x_base_q, i_reg_wr_data, i_reg_wr_strb);
        sa_ctrl_pkg::REG_A_BASE: a_base_q <= merge_bytes(a_base_q, i_reg_wr_data, i_reg_wr_strb);
        sa_ctrl_pkg::REG_Y_BASE: y_base_q <= merge_bytes(y_base_q, i_reg_wr_data, i_reg_wr_strb);
        sa_ctrl_pkg::REG_LEN:    len_q    <= merge_bytes(len_q, i_reg_wr_data, i_reg_wr_strb);
        default: ;
      endcase
    end
  end

  assign start_req = i_reg_wr_en && (wr_idx == sa_ctrl_pkg::REG_CTRL) &&
                     i_reg_wr_strb[0] && i_reg_wr_data[0];

  // Start while busy is dropped, done is sticky until the next start
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_start <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      o_start <= start_req && !busy;
      if (start_req && !busy) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (i_run_end) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (rd_idx)
      sa_ctrl_pkg::REG_STATUS: rd_mux[1:0] = {done, busy};
      sa_ctrl_pkg::REG_K_BASE: rd_mux = k_base_q;
      sa_ctrl_pkg::REG_X_BASE: rd_mux = x_base_q;
      sa_ctrl_pkg::REG_A_BASE: rd_mux = a_base_q;
      sa_ctrl_pkg::REG_Y_BASE: rd_mux = y_base_q;
      sa_ctrl_pkg::REG_LEN:    rd_mux = len_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_reg_rd_data <= '0;
    end else if (i_reg_rd_en) begin
      o_reg_rd_data <= rd_mux;
    end
  end

  assign o_len    = len_q[sa_ctrl_pkg::LEN_W-1:0];
  assign o_k_base = k_base_q[sa_ctrl_pkg::MEM_AW-1:0];
  assign o_x_base = x_base_q[sa_ctrl_pkg::MEM_AW-1:0];
  assign o_a_base = a_base_q[sa_ctrl_pkg::MEM_AW-1:0];
  assign o_y_base = y_base_q[sa_ctrl_pkg::MEM_AW-1:0];

endmodule

//--- design/sa_ram_top.sv
module sa_ram_top (
  input  logic                                clk,
  input  logic                                i_rst_n,
  input  logic                                i_reg_wr_en,
  input  logic [sa_ctrl_pkg::REG_AW-1:0]      i_reg_wr_addr,
  input  logic [sa_ctrl_pkg::REG_DW-1:0]      i_reg_wr_data,
  input  logic [sa_ctrl_pkg::REG_DW/8-1:0]    i_reg_wr_strb,
  input  logic                                i_reg_rd_en,
  input  logic [sa_ctrl_pkg::REG_AW-1:0]      i_reg_rd_addr,
  output logic [sa_ctrl_pkg::REG_DW-1:0]      o_reg_rd_data,
  output logic                                o_k_ren,
  output sa_ctrl_pkg::mem_addr_t              o_k_addr,
  input  sa_cfg_pkg::k_vec_t                  i_k_data,
  output logic                                o_x_ren,
  output sa_ctrl_pkg::mem_addr_t              o_x_addr,
  input  sa_cfg_pkg::x_vec_t                  i_x_data,
  output logic                                o_a_ren,
  output sa_ctrl_pkg::mem_addr_t              o_a_addr,
  input  sa_cfg_pkg::a_vec_t                  i_a_data,
  output logic                                o_y_wen,
  output sa_ctrl_pkg::mem_addr_t              o_y_addr,
  output sa_cfg_pkg::y_vec_t                  o_y_data
);

  logic                          start;
  logic                          run_end;
  logic [sa_ctrl_pkg::LEN_W-1:0] len;
  sa_ctrl_pkg::mem_addr_t        k_base;
  sa_ctrl_pkg::mem_addr_t        x_base;
  sa_ctrl_pkg::mem_addr_t        a_base;
  sa_ctrl_pkg::mem_addr_t        y_base;
  logic                          clr;
  logic                          load_base;
  logic                          kx_next;
  logic                          a_next;
  logic                          k_valid;
  logic                          a_valid;
  sa_cfg_pkg::y_vec_t            col;

  sa_ctrl_regs u_regs (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_reg_wr_en   (i_reg_wr_en),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_wr_strb (i_reg_wr_strb),
    .i_reg_rd_en   (i_reg_rd_en),
    .i_reg_rd_addr (i_reg_rd_addr),
    .i_run_end     (run_end),
    .o_reg_rd_data (o_reg_rd_data),
    .o_start       (start),
    .o_len         (len),
    .o_k_base      (k_base),
    .o_x_base      (x_base),
    .o_a_base      (a_base),
    .o_y_base      (y_base)
  );

  sa_sequencer u_seq (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start),
    .i_len       (len),
    .o_run_end   (run_end),
    .o_clr       (clr),
    .o_load_base (load_base),
    .o_kx_next   (kx_next),
    .o_a_next    (a_next)
  );

  // K and X fetch in lockstep, only K's valid is needed downstream
  mem_reader u_k_rd (
    .clk (clk), .i_rst_n (i_rst_n), .i_load_base (load_base), .i_base (k_base),
    .i_next (kx_next), .o_ren (o_k_ren), .o_addr (o_k_addr), .o_valid (k_valid)
  );

  mem_reader u_x_rd (
    .clk (clk), .i_rst_n (i_rst_n), .i_load_base (load_base), .i_base (x_base),
    .i_next (kx_next), .o_ren (o_x_ren), .o_addr (o_x_addr), .o_valid ()
  );

  mem_reader u_a_rd (
    .clk (clk), .i_rst_n (i_rst_n), .i_load_base (load_base), .i_base (a_base),
    .i_next (a_next), .o_ren (o_a_ren), .o_addr (o_a_addr), .o_valid (a_valid)
  );

  pe_array u_pe (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_clr    (clr),
    .i_acc_en (k_valid),
    .i_k      (i_k_data),
    .i_x      (i_x_data),
    .i_drain  (a_valid),
    .o_col    (col)
  );

  bias_writer u_bias (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_load_base (load_base),
    .i_y_base    (y_base),
    .i_valid     (a_valid),
    .i_col       (col),
    .i_bias      (i_a_data),
    .o_wen       (o_y_wen),
    .o_addr      (o_y_addr),
    .o_data      (o_y_data)
  );

endmodule

//--- design/sa_sequencer.sv
module sa_sequencer (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_start,
  input  logic [sa_ctrl_pkg::LEN_W-1:0] i_len,
  output logic                          o_run_end,
  output logic                          o_clr,
  output logic                          o_load_base,
  output logic                          o_kx_next,
  output logic                          o_a_next
);

  sa_ctrl_pkg::seq_state_e       state;
  logic [sa_ctrl_pkg::LEN_W-1:0] beat_cnt;
  logic                          last_beat;

  // Each phase ends on its own beat count
  always_comb begin
    case (state)
      sa_ctrl_pkg::LOAD:   last_beat = (beat_cnt == i_len - 1'b1);
      sa_ctrl_pkg::DRAIN:  last_beat = (beat_cnt == sa_cfg_pkg::C - 1);
      sa_ctrl_pkg::FINISH: last_beat = (beat_cnt == sa_ctrl_pkg::FINISH_CYC - 1);
      default:             last_beat = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state    <= sa_ctrl_pkg::IDLE;
      beat_cnt <= '0;
    end else begin
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      case (state)
        sa_ctrl_pkg::IDLE: begin
          beat_cnt <= '0;
          if (i_start) begin
            state <= sa_ctrl_pkg::LOAD;
          end
        end
        sa_ctrl_pkg::LOAD:   if (last_beat) state <= sa_ctrl_pkg::DRAIN;
        sa_ctrl_pkg::DRAIN:  if (last_beat) state <= sa_ctrl_pkg::FINISH;
        sa_ctrl_pkg::FINISH: if (last_beat) state <= sa_ctrl_pkg::IDLE;
        default:             state <= sa_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Clear the array and rewind the readers as the run starts
  assign o_clr       = (state == sa_ctrl_pkg::IDLE) && i_start;
  assign o_load_base = o_clr;
  assign o_kx_next   = (state == sa_ctrl_pkg::LOAD);
  assign o_a_next    = (state == sa_ctrl_pkg::DRAIN);
  assign o_run_end   = (state == sa_ctrl_pkg::FINISH) && last_beat;

endmodule

//--- flist.f
design/sa_cfg_pkg.sv
design/sa_ctrl_pkg.sv
design/mem_reader.sv
design/pe_array.sv
design/bias_writer.sv
design/sa_ctrl_regs.sv
design/sa_sequencer.sv
design/sa_ram_top.sv
tb/tb_clk_gen.sv
tb/sa_ram_tb.sv

//--- tb/sa_ram_tb.sv
module sa_ram_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Five runs of at most about 60 cycles plus register traffic and a wide margin
  localparam int MAX_CYCLES = 4000;
  localparam int MEM_WORDS  = 2 ** sa_ctrl_pkg::MEM_AW;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_wr_en;
  logic [31:0]            reg_wr_addr;
  logic [31:0]            reg_wr_data;
  logic [3:0]             reg_wr_strb;
  logic                   reg_rd_en;
  logic [31:0]            reg_rd_addr;
  logic [31:0]            reg_rd_data;
  logic                   k_ren;
  logic                   x_ren;
  logic                   a_ren;
  logic                   y_wen;
  sa_ctrl_pkg::mem_addr_t k_addr;
  sa_ctrl_pkg::mem_addr_t x_addr;
  sa_ctrl_pkg::mem_addr_t a_addr;
  sa_ctrl_pkg::mem_addr_t y_addr;
  sa_cfg_pkg::k_vec_t     k_data;
  sa_cfg_pkg::x_vec_t     x_data;
  sa_cfg_pkg::a_vec_t     a_data;
  sa_cfg_pkg::y_vec_t     y_data;

  sa_cfg_pkg::k_vec_t     k_mem [MEM_WORDS];
  sa_cfg_pkg::x_vec_t     x_mem [MEM_WORDS];
  sa_cfg_pkg::a_vec_t     a_mem [MEM_WORDS];
  sa_cfg_pkg::y_vec_t     y_mem [MEM_WORDS];

  logic                   k_pend;
  logic                   x_pend;
  logic                   a_pend;
  sa_ctrl_pkg::mem_addr_t k_pend_addr;
  sa_ctrl_pkg::mem_addr_t x_pend_addr;
  sa_ctrl_pkg::mem_addr_t a_pend_addr;

  int unsigned            rng_state = 79378;
  int                     cycle_cnt = 0;
  int                     wr_count;
  bit                     start_issued;
  sa_ctrl_pkg::mem_addr_t exp_addr_q [$];
  sa_cfg_pkg::y_vec_t     exp_data_q [$];

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  sa_ram_top i_dut (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_reg_wr_en   (reg_wr_en),
    .i_reg_wr_addr (reg_wr_addr),
    .i_reg_wr_data (reg_wr_data),
    .i_reg_wr_strb (reg_wr_strb),
    .i_reg_rd_en   (reg_rd_en),
    .i_reg_rd_addr (reg_rd_addr),
    .o_reg_rd_data (reg_rd_data),
    .o_k_ren       (k_ren),
    .o_k_addr      (k_addr),
    .i_k_data      (k_data),
    .o_x_ren       (x_ren),
    .o_x_addr      (x_addr),
    .i_x_data      (x_data),
    .o_a_ren       (a_ren),
    .o_a_addr      (a_addr),
    .i_a_data      (a_data),
    .o_y_wen       (y_wen),
    .o_y_addr      (y_addr),
    .o_y_data      (y_data)
  );

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] masked_update(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // Expected Y beat for column c is the sum of x[r]*k[c] over the burst plus bias
  function automatic sa_cfg_pkg::y_vec_t ref_column(input int len, input int kb, input int xb,
                                                    input int ab, input int c);
    sa_cfg_pkg::y_vec_t y;
    int sum;
    int xv;
    int kv;
    for (int r = 0; r < sa_cfg_pkg::R; r++) begin
      sum = 0;
      for (int i = 0; i < len; i++) begin
        xv = $signed(x_mem[xb + i][r]);
        kv = $signed(k_mem[kb + i][c]);
        sum = sum + xv * kv;
      end
      sum = sum + int'(a_mem[ab + c][r]);
      y[r] = sum;
    end
    return y;
  endfunction

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic reg_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
    @(negedge clk);
    reg_wr_en   = 1'b1;
    reg_wr_addr = sa_ctrl_pkg::REG_BASE_ADDR + 32'(idx) * 4;
    reg_wr_data = data;
    reg_wr_strb = strb;
    @(negedge clk);
    reg_wr_en   = 1'b0;
  endtask

  task automatic reg_read(input int idx, output logic [31:0] data);
    @(negedge clk);
    reg_rd_en   = 1'b1;
    reg_rd_addr = sa_ctrl_pkg::REG_BASE_ADDR + 32'(idx) * 4;
    @(negedge clk);
    reg_rd_en   = 1'b0;
    data        = reg_rd_data;
  endtask

  task automatic do_run(input int len, input int kb, input int xb, input int ab,
                        input int yb, input bit try_restart);
    logic [31:0] status;
    for (int c = 0; c < sa_cfg_pkg::C; c++) begin
      exp_addr_q.push_back(sa_ctrl_pkg::mem_addr_t'(yb + c));
      exp_data_q.push_back(ref_column(len, kb, xb, ab, c));
    end
    wr_count = 0;
    reg_write(sa_ctrl_pkg::REG_K_BASE, kb, 4'hF);
    reg_write(sa_ctrl_pkg::REG_X_BASE, xb, 4'hF);
    reg_write(sa_ctrl_pkg::REG_A_BASE, ab, 4'hF);
    reg_write(sa_ctrl_pkg::REG_Y_BASE, yb, 4'hF);
    reg_write(sa_ctrl_pkg::REG_LEN, len, 4'hF);
    start_issued = 1'b1;
    reg_write(sa_ctrl_pkg::REG_CTRL, 32'h1, 4'hF);
    // Busy set and the previous done cleared
    reg_read(sa_ctrl_pkg::REG_STATUS, status);
    check_value("o_reg_rd_data (STATUS after start)", status, 32'h1);
    if (try_restart) begin
      reg_write(sa_ctrl_pkg::REG_CTRL, 32'h1, 4'hF);
    end
    do begin
      reg_read(sa_ctrl_pkg::REG_STATUS, status);
    end while (!status[1]);
    check_value("o_reg_rd_data (STATUS at end)", status, 32'h2);
    if (try_restart) begin
      repeat (30) @(negedge clk);
    end
    check_value("Y write count", wr_count, sa_cfg_pkg::C);
    assert (exp_addr_q.size() == 0) else begin
      $display("Run ended with %0d expected Y writes missing", exp_addr_q.size());
      stop_on_failure();
    end
  endtask

  // RAM models answer a strobe seen on one falling edge at the next one
  always @(negedge clk) begin
    k_data      = k_pend ? k_mem[k_pend_addr] : '0;
    x_data      = x_pend ? x_mem[x_pend_addr] : '0;
    a_data      = a_pend ? a_mem[a_pend_addr] : '0;
    k_pend      = rst_n && k_ren;
    x_pend      = rst_n && x_ren;
    a_pend      = rst_n && a_ren;
    k_pend_addr = k_addr;
    x_pend_addr = x_addr;
    a_pend_addr = a_addr;
  end

  always @(negedge clk) begin : compare_writes
    sa_ctrl_pkg::mem_addr_t ea;
    sa_cfg_pkg::y_vec_t     ed;
    if (rst_n && !start_issued) begin
      assert (!(k_ren || x_ren || a_ren || y_wen)) else begin
        $display("A RAM strobe was active before the first start");
        stop_on_failure();
      end
    end
    if (rst_n && y_wen) begin
      if (exp_addr_q.size() == 0) begin
        $display("Unexpected write to the Y RAM at address 0x%h", y_addr);
        stop_on_failure();
      end else begin
        ea = exp_addr_q.pop_front();
        ed = exp_data_q.pop_front();
        y_mem[y_addr] = y_data;
        wr_count++;
        check_value("o_y_addr", y_addr, ea);
        check_value("o_y_data", y_mem[ea], ed);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles without finishing the tests", MAX_CYCLES);
      stop_on_failure();
    end
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic [3:0]  strb;
    int          len;
    reg_wr_en    = 1'b0;
    reg_wr_addr  = '0;
    reg_wr_data  = '0;
    reg_wr_strb  = '0;
    reg_rd_en    = 1'b0;
    reg_rd_addr  = '0;
    k_data       = '0;
    x_data       = '0;
    a_data       = '0;
    k_pend       = 1'b0;
    x_pend       = 1'b0;
    a_pend       = 1'b0;
    start_issued = 1'b0;
    @(posedge rst_n);

    for (int idx = 1; idx <= 6; idx++) begin
      reg_read(idx, rd);
      check_value("o_reg_rd_data (after reset)", rd, 32'h0);
    end

    // Partial byte writes
    for (int idx = 2; idx <= 6; idx++) begin
      old_val = rand32();
      new_val = rand32();
      strb    = rand32();
      reg_write(idx, old_val, 4'hF);
      reg_write(idx, new_val, strb);
      reg_read(idx, rd);
      check_value("o_reg_rd_data (byte strobes)", rd, masked_update(old_val, new_val, strb));
    end
    reg_write(7, 32'hFFFF_FFFF, 4'hF);
    reg_read(7, rd);
    check_value("o_reg_rd_data (index 7)", rd, 32'h0);
    reg_read(63, rd);
    check_value("o_reg_rd_data (index 63)", rd, 32'h0);

    // Known values over a single beat
    for (int c = 0; c < sa_cfg_pkg::C; c++) begin
      k_mem[16'h0100][c] = 8'(c + 1);
      a_mem[16'h0300 + c] = {32'(100 * c + 3), 32'(100 * c + 2), 32'(100 * c + 1), 32'(100 * c)};
    end
    for (int r = 0; r < sa_cfg_pkg::R; r++) begin
      x_mem[16'h0200][r] = 8'(r - 2);
    end
    do_run(1, 16'h0100, 16'h0200, 16'h0300, 16'h0400, 1'b0);

    // Random runs where the last one also tries a restart while busy
    for (int run = 0; run < 4; run++) begin
      int kb;
      int xb;
      int ab;
      int yb;
      len = (rand32() % 8) + 1;
      // Restart run keeps a longer burst
      if (run == 3 && len < 4) begin
        len = len + 4;
      end
      kb  = 16'h1000 + (rand32() & 32'h0FFF);
      xb  = 16'h3000 + (rand32() & 32'h0FFF);
      ab  = 16'h5000 + (rand32() & 32'h0FFF);
      yb  = 16'h7000 + (rand32() & 32'h0FFF);
      for (int i = 0; i < len; i++) begin
        k_mem[kb + i] = rand32();
        x_mem[xb + i] = rand32();
      end
      for (int c = 0; c < sa_cfg_pkg::C; c++) begin
        a_mem[ab + c] = {rand32(), rand32(), rand32(), rand32()};
      end
      do_run(len, kb, xb, ab, yb, run == 3);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 16;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule
